// File: compile.f
nn_fixed_pkg.sv
nn_shape_pkg.sv
sample_loader.sv
forward_stage.sv
gradient_stage.sv
weight_store.sv
nn_trainer.sv
tb_clock.sv
nn_checker.sv
nn_assertions.sv
tb_nn_trainer.sv

// File: Bender.yml
package:
  name: nn_trainer

sources:
  - files:
      - nn_fixed_pkg.sv
      - nn_shape_pkg.sv
      - sample_loader.sv
      - forward_stage.sv
      - gradient_stage.sv
      - weight_store.sv
      - nn_trainer.sv
  - target: test
    files:
      - tb_clock.sv
      - nn_checker.sv
      - nn_assertions.sv
      - tb_nn_trainer.sv

// File: tb_nn_trainer.sv
`timescale 1ns/100ps

module tb_nn_trainer
	import nn_fixed_pkg::*;
();

	localparam int N_FIRST    = 60;      // samples before the reload
	localparam int N_SECOND   = 20;      // samples after it
	localparam int LOAD_BEATS = 12 + 3;  // w1 plus w2 beats
	localparam int MAX_GAP    = 5;
	localparam int DRAIN      = 8;       // idle cycles to empty the pipeline
	localparam int CYCLE_LIMIT = 2 * (8 + 2 * (LOAD_BEATS + 4 + DRAIN)
		+ (N_FIRST + N_SECOND) * (4 + MAX_GAP));

	logic        clk;
	logic        rst_n;
	logic [4:0]  epoch;
	logic        in_valid_d;
	logic        in_valid_t;
	logic        in_valid_w1;
	logic        in_valid_w2;
	fx_t         data_point;
	fx_t         target;
	fx_t         weight1;
	fx_t         weight2;
	logic        out_valid;
	fx_t         out;
	int          error_count;
	int          compare_count;
	logic [15:0] lfsr;        // random state
	int          cycle_count;
	int          tb_errors;

	tb_clock   u_clock (.*);
	nn_trainer u_dut (.*);
	nn_checker u_checker (.*);

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] st);
		logic fb;
		fb = st[15] ^ st[13] ^ st[12] ^ st[10];
		return {st[14:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	// signed 10-bit draw, about +-2.0 in q8.8
	task automatic rand_fx(output fx_t v);
		logic [15:0] bits;
		take_bits(10, bits);
		v = {{6{bits[9]}}, bits[9:0]};
	endtask

	// --------------------
	// bus drivers
	// --------------------
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			in_valid_d  = 1'b0;
			in_valid_t  = 1'b0;
			in_valid_w1 = 1'b0;
			in_valid_w2 = 1'b0;
			data_point  = '0;
			target      = '0;
		end
	endtask

	task automatic load_weights();
		for (int k = 0; k < 12; k++) begin
			@(posedge clk);
			#2;
			in_valid_w1 = 1'b1;
			rand_fx(weight1); // lands at index 0 after 12 beats
		end
		for (int k = 0; k < 3; k++) begin
			@(posedge clk);
			#2;
			in_valid_w1 = 1'b0;
			in_valid_w2 = 1'b1;
			rand_fx(weight2);
		end
	endtask

	task automatic send_sample(input logic [4:0] ep);
		for (int j = 0; j < 4; j++) begin
			@(posedge clk);
			#2;
			in_valid_d = 1'b1;
			in_valid_t = (j == 0); // target and epoch on input 0
			epoch      = ep;
			rand_fx(data_point);
			if (j == 0) begin
				rand_fx(target);
			end else begin
				target = '0;
			end
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		logic [15:0] gap;
		lfsr        = 16'd88;
		epoch       = '0;
		in_valid_d  = 1'b0;
		in_valid_t  = 1'b0;
		in_valid_w1 = 1'b0;
		in_valid_w2 = 1'b0;
		data_point  = '0;
		target      = '0;
		weight1     = '0;
		weight2     = '0;
		tb_errors   = 0;
		@(posedge rst_n);
		idle_cycles(2);
		load_weights();
		idle_cycles(2);
		for (int n = 0; n < N_FIRST; n++) begin
			send_sample(5'(n * 25 / N_FIRST)); // epochs 0..24
			take_bits(2, gap);
			idle_cycles(2 + gap); // 2 to 5 idle cycles
		end
		idle_cycles(DRAIN);
		load_weights(); // replaces the trained weights
		idle_cycles(2);
		for (int n = 0; n < N_SECOND; n++) begin
			send_sample(5'(n * 25 / N_SECOND));
			take_bits(2, gap);
			idle_cycles(2 + gap);
		end
		idle_cycles(DRAIN);
		if (compare_count != N_FIRST + N_SECOND) begin
			$display("expected %0d outputs but compared %0d", N_FIRST + N_SECOND, compare_count);
			tb_errors++;
		end
		$display("errors: checker %0d, assertions %0d, testbench %0d (outputs compared %0d)",
			error_count, u_dut.u_assertions.fail_count, tb_errors, compare_count);
		if (error_count + u_dut.u_assertions.fail_count + tb_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: nn_assertions.sv
`timescale 1ns/100ps

module nn_assertions (
	input logic clk,
	input logic rst_n,
	input logic in_valid_d,
	input logic in_valid_t,
	input logic in_valid_w1,
	input logic out_valid
);

	int fail_count = 0; // failed assertion count

	out_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else begin
			$error("out_valid high in two consecutive cycles");
			fail_count++;
		end

	target_with_data: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid_t |-> in_valid_d)
		else begin
			$error("in_valid_t without in_valid_d");
			fail_count++;
		end

	no_load_during_data: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid_w1 && in_valid_d))
		else begin
			$error("in_valid_w1 and in_valid_d high together");
			fail_count++;
		end

endmodule

bind nn_trainer nn_assertions u_assertions (.*);

// File: nn_checker.sv
`timescale 1ns/100ps

module nn_checker
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid_d,
	input  logic   in_valid_t,
	input  logic   in_valid_w1,
	input  logic   in_valid_w2,
	input  fx_t    data_point,
	input  fx_t    target,
	input  epoch_t epoch,
	input  fx_t    weight1,
	input  fx_t    weight2,
	input  logic   out_valid,
	input  fx_t    out,
	output int     error_count,
	output int     compare_count
);

	fx_t    m_w1 [W1_COUNT]; // model copy of layer 1
	fx_t    m_w2 [W2_COUNT]; // model copy of layer 2
	fx_t    m_s [IN_DIM];    // current sample
	fx_t    m_tgt;
	int     m_shift;         // learning-rate shift of the sample
	int     beat_cnt;
	longint cycle;           // edges since reset
	fx_t    exp_out [$];     // expected outputs, oldest first
	longint exp_cycle [$];   // edge where each one is due
	int     errs = 0;
	int     compared = 0;

	assign error_count   = errs;
	assign compare_count = compared;

	// drop 8 fraction bits, keep 16
	function automatic fx_t rescale(input acc_t a);
		acc_t sh;
		sh = a >>> FRAC_BITS;
		return sh[15:0];
	endfunction

	// --------------------
	// model of one training step
	// --------------------
	task automatic train_step();
		fx_t  h [HID_DIM];
		fx_t  y [HID_DIM];
		fx_t  d [HID_DIM];
		fx_t  o;
		fx_t  err;
		fx_t  g2;
		acc_t sum;
		for (int i = 0; i < HID_DIM; i++) begin
			sum = 0;
			for (int j = 0; j < IN_DIM; j++) begin
				sum += acc_t'(m_s[j]) * acc_t'(m_w1[i*IN_DIM + j]);
			end
			h[i] = rescale(sum);
			y[i] = (h[i] > 0) ? h[i] : fx_t'(0); // relu
		end
		sum = 0;
		for (int i = 0; i < HID_DIM; i++) begin
			sum += acc_t'(y[i]) * acc_t'(m_w2[i]);
		end
		o   = rescale(sum);
		err = o - m_tgt;         // 16-bit wrap
		g2  = err >>> m_shift;   // learning rate
		for (int i = 0; i < HID_DIM; i++) begin
			d[i] = (h[i] > 0) ? rescale(acc_t'(g2) * acc_t'(m_w2[i])) : fx_t'(0); // old w2
		end
		for (int i = 0; i < HID_DIM; i++) begin
			m_w2[i] = m_w2[i] - rescale(acc_t'(g2) * acc_t'(y[i]));
			for (int j = 0; j < IN_DIM; j++) begin
				m_w1[i*IN_DIM + j] = m_w1[i*IN_DIM + j] - rescale(acc_t'(d[i]) * acc_t'(m_s[j]));
			end
		end
		exp_out.push_back(o);
		exp_cycle.push_back(cycle + 3); // fixed 3-cycle latency
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_w1     = '{default: '0};
			m_w2     = '{default: '0};
			beat_cnt = 0;
			cycle    = 0;
			exp_out.delete();
			exp_cycle.delete();
		end else begin
			cycle++;
			// output side, values from before this edge
			if (out_valid) begin
				if (exp_cycle.size() == 0 || exp_cycle[0] != cycle) begin
					$display("out_valid pulse at cycle %0d with no output due", cycle);
					errs++;
				end else begin
					if (out !== exp_out[0]) begin
						$display("MISMATCH out: got 0x%04h, expected 0x%04h (output %0d)",
							out, exp_out[0], compared);
						errs++;
					end
					compared++;
					void'(exp_out.pop_front());
					void'(exp_cycle.pop_front());
				end
			end
			if (exp_cycle.size() > 0 && exp_cycle[0] <= cycle) begin
				$display("missing out_valid, output was due at cycle %0d", exp_cycle[0]);
				errs++;
				void'(exp_out.pop_front());
				void'(exp_cycle.pop_front());
			end
			// ----------------------
			// input side
			// ----------------------
			if (in_valid_w1) begin
				for (int k = 0; k < W1_COUNT - 1; k++) begin
					m_w1[k] = m_w1[k+1];
				end
				m_w1[W1_COUNT-1] = weight1;
			end
			if (in_valid_w2) begin
				for (int k = 0; k < W2_COUNT - 1; k++) begin
					m_w2[k] = m_w2[k+1];
				end
				m_w2[W2_COUNT-1] = weight2;
			end
			if (in_valid_d) begin
				m_s[beat_cnt] = data_point;
				if (in_valid_t) begin
					m_tgt   = target;
					m_shift = LR_BASE_SHIFT + epoch / LR_STEP_EPOCHS; // halves every 4 epochs
				end
				if (beat_cnt == IN_DIM - 1) begin
					train_step(); // last beat, sample complete
					beat_cnt = 0;
				end else begin
					beat_cnt++;
				end
			end else begin
				beat_cnt = 0;
			end
		end
	end

endmodule

// File: tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	localparam time HALF_PERIOD = 20ns; // 40 ns clock

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk); // reset held for 8 cycles
		#2;
		rst_n = 1'b1; // released off the edge, like the stimulus
	end

endmodule

// File: nn_trainer.sv
`timescale 1ns/100ps

module nn_trainer
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  epoch_t epoch,
	input  logic   in_valid_d,
	input  logic   in_valid_t,
	input  logic   in_valid_w1,
	input  logic   in_valid_w2,
	input  fx_t    data_point,
	input  fx_t    target,
	input  fx_t    weight1,
	input  fx_t    weight2,
	output logic   out_valid,
	output fx_t    out
);

	// --------------------
	// stage wires
	// --------------------
	logic   sample_valid;       // loader -> forward
	fx_t    s [IN_DIM];
	fx_t    tgt;
	shift_t lr_shift;
	logic   hid_valid;          // forward -> gradient
	fx_t    h [HID_DIM];
	fx_t    y [HID_DIM];
	fx_t    s_q [IN_DIM];
	fx_t    tgt_q;
	shift_t lr_shift_q;
	logic   grad_valid;         // gradient -> weights
	fx_t    g2;
	fx_t    d [HID_DIM];
	fx_t    y_g [HID_DIM];
	fx_t    s_g [IN_DIM];
	fx_t    w1 [W1_COUNT];      // weights -> forward
	fx_t    w2 [W2_COUNT];

	sample_loader u_loader (
		.clk(clk), .rst_n(rst_n), .in_valid_d(in_valid_d), .in_valid_t(in_valid_t),
		.data_point(data_point), .target(target), .epoch(epoch),
		.sample_valid(sample_valid), .s(s), .tgt(tgt), .lr_shift(lr_shift)
	);

	forward_stage u_forward (
		.clk(clk), .rst_n(rst_n), .sample_valid(sample_valid), .s(s), .tgt(tgt),
		.lr_shift(lr_shift), .w1(w1), .w2(w2), .hid_valid(hid_valid), .h(h), .y(y),
		.s_q(s_q), .tgt_q(tgt_q), .lr_shift_q(lr_shift_q), .out_valid(out_valid), .out(out)
	);

	gradient_stage u_gradient (
		.clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out(out), .tgt_q(tgt_q),
		.lr_shift_q(lr_shift_q), .h(h), .y(y), .s_q(s_q), .w2(w2),
		.grad_valid(grad_valid), .g2(g2), .d(d), .y_g(y_g), .s_g(s_g)
	);

	weight_store u_weights (
		.clk(clk), .rst_n(rst_n), .in_valid_w1(in_valid_w1), .in_valid_w2(in_valid_w2),
		.weight1(weight1), .weight2(weight2), .grad_valid(grad_valid), .g2(g2), .d(d),
		.y_g(y_g), .s_g(s_g), .w1(w1), .w2(w2)
	);

endmodule

// File: weight_store.sv
`timescale 1ns/100ps

module weight_store
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid_w1,
	input  logic in_valid_w2,
	input  fx_t  weight1,
	input  fx_t  weight2,
	input  logic grad_valid,
	input  fx_t  g2,
	input  fx_t  d [HID_DIM],
	input  fx_t  y_g [HID_DIM],
	input  fx_t  s_g [IN_DIM],
	output fx_t  w1 [W1_COUNT],
	output fx_t  w2 [W2_COUNT]
);

	acc_t w1_grad [W1_COUNT]; // d_i * s_j
	acc_t w2_grad [W2_COUNT]; // g2 * y_i

	// --------------------
	// gradient products
	// --------------------
	always_comb begin
		for (int i = 0; i < HID_DIM; i++) begin
			for (int j = 0; j < IN_DIM; j++) begin
				w1_grad[i*IN_DIM + j] = acc_t'(d[i]) * acc_t'(s_g[j]);
			end
			w2_grad[i] = acc_t'(g2) * acc_t'(y_g[i]);
		end
	end

	// --------------------
	// layer 1
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w1 <= '{default: '0};
		end else if (in_valid_w1) begin
			for (int k = 0; k < W1_COUNT - 1; k++) begin
				w1[k] <= w1[k+1]; // shift chain toward index 0
			end
			w1[W1_COUNT-1] <= weight1; // newest beat enters at the top
		end else if (grad_valid) begin
			for (int k = 0; k < W1_COUNT; k++) begin
				w1[k] <= w1[k] - fx_t'(w1_grad[k] >>> FRAC_BITS); // sgd step
			end
		end
	end

	// --------------------
	// layer 2
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w2 <= '{default: '0};
		end else if (in_valid_w2) begin
			w2[0] <= w2[1];
			w2[1] <= w2[2];
			w2[W2_COUNT-1] <= weight2; // load wins over update
		end else if (grad_valid) begin
			for (int k = 0; k < W2_COUNT; k++) begin
				w2[k] <= w2[k] - fx_t'(w2_grad[k] >>> FRAC_BITS);
			end
		end
	end

endmodule

// File: gradient_stage.sv
`timescale 1ns/100ps

module gradient_stage
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   out_valid,
	input  fx_t    out,
	input  fx_t    tgt_q,
	input  shift_t lr_shift_q,
	input  fx_t    h [HID_DIM],
	input  fx_t    y [HID_DIM],
	input  fx_t    s_q [IN_DIM],
	input  fx_t    w2 [W2_COUNT],
	output logic   grad_valid,
	output fx_t    g2,
	output fx_t    d [HID_DIM],
	output fx_t    y_g [HID_DIM],
	output fx_t    s_g [IN_DIM]
);

	fx_t  err;             // out - target
	fx_t  g2_next;         // scaled output delta
	acc_t d_acc [HID_DIM]; // g2 * w2, pre-update weights

	always_comb begin
		err     = out - tgt_q;        // 16-bit wrap
		g2_next = err >>> lr_shift_q; // learning rate as arithmetic shift
		for (int i = 0; i < HID_DIM; i++) begin
			d_acc[i] = acc_t'(g2_next) * acc_t'(w2[i]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grad_valid <= 1'b0;
		end else begin
			grad_valid <= out_valid;
		end
	end

	// deltas and carried activations
	always_ff @(posedge clk) begin
		if (out_valid) begin
			g2 <= g2_next;
			for (int i = 0; i < HID_DIM; i++) begin
				d[i] <= (h[i] > 0) ? fx_t'(d_acc[i] >>> FRAC_BITS) : '0; // relu gate
			end
			y_g <= y;   // for w2 gradient
			s_g <= s_q; // for w1 gradient
		end
	end

endmodule

// File: forward_stage.sv
`timescale 1ns/100ps

module forward_stage
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   sample_valid,
	input  fx_t    s [IN_DIM],
	input  fx_t    tgt,
	input  shift_t lr_shift,
	input  fx_t    w1 [W1_COUNT],
	input  fx_t    w2 [W2_COUNT],
	output logic   hid_valid,
	output fx_t    h [HID_DIM],
	output fx_t    y [HID_DIM],
	output fx_t    s_q [IN_DIM],
	output fx_t    tgt_q,
	output shift_t lr_shift_q,
	output logic   out_valid,
	output fx_t    out
);

	acc_t hid_acc [HID_DIM]; // raw hidden sums
	fx_t  hid_sum [HID_DIM]; // rescaled, before relu
	acc_t out_acc;           // raw output neuron sum

	// --------------------
	// hidden layer
	// --------------------
	always_comb begin
		for (int i = 0; i < HID_DIM; i++) begin
			hid_acc[i] = '0;
			for (int j = 0; j < IN_DIM; j++) begin
				hid_acc[i] = hid_acc[i] + acc_t'(s[j]) * acc_t'(w1[i*IN_DIM + j]);
			end
			hid_sum[i] = fx_t'(hid_acc[i] >>> FRAC_BITS); // rescale
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			for (int i = 0; i < HID_DIM; i++) begin
				h[i] <= hid_sum[i];
				y[i] <= (hid_sum[i] > 0) ? hid_sum[i] : '0; // relu, zero stays zero
			end
			s_q        <= s;        // kept for the w1 update
			tgt_q      <= tgt;
			lr_shift_q <= lr_shift;
		end
	end

	// --------------------
	// output neuron
	// --------------------
	always_comb begin
		out_acc = '0;
		for (int i = 0; i < HID_DIM; i++) begin
			out_acc = out_acc + acc_t'(y[i]) * acc_t'(w2[i]); // 3 products
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hid_valid <= 1'b0;
			out_valid <= 1'b0;
			out       <= '0;
		end else begin
			hid_valid <= sample_valid;
			out_valid <= hid_valid; // single pulse per sample
			out       <= hid_valid ? fx_t'(out_acc >>> FRAC_BITS) : '0; // idle reads zero
		end
	end

endmodule

// File: sample_loader.sv
`timescale 1ns/100ps

module sample_loader
	import nn_fixed_pkg::*, nn_shape_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid_d,
	input  logic   in_valid_t,
	input  fx_t    data_point,
	input  fx_t    target,
	input  epoch_t epoch,
	output logic   sample_valid,
	output fx_t    s [IN_DIM],
	output fx_t    tgt,
	output shift_t lr_shift
);

	in_idx_t beat_idx;  // slot of the next data point
	epoch_t  epoch_q;   // epoch of the current sample
	epoch_t  epoch_lim; // clamped to the schedule

	// beat counter, restarts whenever the data stream pauses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_idx     <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= in_valid_d && (beat_idx == in_idx_t'(IN_DIM - 1)); // 4th beat
			if (in_valid_d) begin
				beat_idx <= beat_idx + 1'b1; // wraps after input 3
			end else begin
				beat_idx <= '0; // gap between samples
			end
		end
	end

	// sample payload
	always_ff @(posedge clk) begin
		if (in_valid_d) begin
			s[beat_idx] <= data_point; // serial placement, input 0 first
		end
		if (in_valid_t) begin
			tgt     <= target; // comes with the first beat
			epoch_q <= epoch;  // same beat
		end
	end

	// rate halves every LR_STEP_EPOCHS epochs
	always_comb begin
		epoch_lim = (epoch_q > epoch_t'(EPOCH_MAX)) ? epoch_t'(EPOCH_MAX) : epoch_q;
		lr_shift  = shift_t'(LR_BASE_SHIFT + epoch_lim / LR_STEP_EPOCHS); // 4..10
	end

endmodule

// File: nn_shape_pkg.sv
package nn_shape_pkg;

	// --------------------
	// network shape
	// --------------------

	localparam int IN_DIM   = 4;  // data points per sample
	localparam int HID_DIM  = 3;  // hidden relu units
	localparam int W1_COUNT = 12; // index is hidden * 4 + input
	localparam int W2_COUNT = 3;  // one per hidden unit

	// --------------------
	// training schedule
	// --------------------

	localparam int EPOCH_MAX      = 24; // last epoch of a run
	localparam int LR_BASE_SHIFT  = 4;  // error shift in epochs 0..3
	localparam int LR_STEP_EPOCHS = 4;  // epochs per extra halving

	// --------------------
	// index types
	// --------------------

	typedef logic [4:0] epoch_t;  // epoch number 0..24
	typedef logic [1:0] in_idx_t; // data-point slot
	typedef logic [3:0] shift_t;  // learning-rate shift

endpackage

// File: nn_fixed_pkg.sv
package nn_fixed_pkg;

	// --------------------
	// q8.8 number format
	// --------------------

	// signed, wraps on overflow
	localparam int FRAC_BITS = 8; // fraction bits, also the rescale shift

	// data, target, weights, activations, deltas
	typedef logic signed [15:0] fx_t;

	// full product or sum of products, rescaled later
	typedef logic signed [31:0] acc_t;

	// --------------------
	// rescale convention
	// --------------------

	// acc_t >>> FRAC_BITS, then keep the low 16 bits
	// every product in the design goes through this step

endpackage
